/* logic/calcPkg.sv */
// Shared constants of the calculator core
// Imported by every RTL module for the default width and the accumulator commands
`default_nettype none

package calcPkg;

	// ------------------------------
	// Width
	// ------------------------------

	// Default W of the two's-complement accumulator
	localparam int defaultWidth = 11;

	// ------------------------------
	// Accumulator commands
	// ------------------------------

	localparam int accCmdWidth = 3;

	// A keeps its value
	localparam logic [accCmdWidth-1:0] accHold = 3'd0;
	// A becomes zero
	localparam logic [accCmdWidth-1:0] accClear = 3'd1;
	// A takes the latched operand
	localparam logic [accCmdWidth-1:0] accLoadNumber = 3'd2;
	// A takes the adder result
	localparam logic [accCmdWidth-1:0] accLoadSum = 3'd3;
	// A takes the low W bits of the product
	localparam logic [accCmdWidth-1:0] accLoadProduct = 3'd4;

endpackage

`default_nettype wire

/* logic/operandLatch.sv */
// Operand register fed from the switches
// Converts sign-magnitude Number to two's complement while entry is open
`default_nettype none
`timescale 1ns/10ps

module operandLatch import calcPkg::*; #(
	parameter int Width = defaultWidth
) (
	input wire Clock,
	input wire reset,
	input wire captureNumber,
	input wire [Width-1:0] Number,
	output logic [Width-1:0] operand
);

	logic [Width-1:0] magnitude;
	logic [Width-1:0] converted;

	// Magnitude with the sign bit dropped
	assign magnitude = {1'b0, Number[Width-2:0]};

	// Negate when the sign is set
	// negative zero ends up as plain zero
	assign converted = Number[Width-1] ? (~magnitude + 1'b1) : magnitude;

	// Follows Number during entry and holds afterwards
	always_ff @(posedge Clock) begin
		if (reset) begin
			operand <= '0;
		end else if (captureNumber) begin
			operand <= converted;
		end
	end

endmodule

`default_nettype wire

/* logic/addSub.sv */
// Ripple-carry adder/subtractor with signed overflow
// Shared by plain add, plain subtract and the Booth steps
`default_nettype none
`timescale 1ns/10ps

module addSub import calcPkg::*; #(
	parameter int Width = defaultWidth
) (
	input wire [Width-1:0] a,
	input wire [Width-1:0] b,
	input wire subtract,
	output logic [Width-1:0] sum,
	output logic overflow
);

	logic [Width:0] carry;
	logic [Width-1:0] bInv;

	// Subtract means a + ~b + 1
	assign bInv = b ^ {Width{subtract}};
	assign carry[0] = subtract;

	// ------------------------------
	// Full-adder chain
	// ------------------------------

	for (genvar i = 0; i < Width; i++) begin : gCell
		assign sum[i] = a[i] ^ bInv[i] ^ carry[i];
		// Generate or propagate
		assign carry[i+1] = (a[i] & bInv[i]) | (carry[i] & (a[i] ^ bInv[i]));
	end

	// Carry into and out of the sign bit disagree
	assign overflow = carry[Width] ^ carry[Width-1];

endmodule

`default_nettype wire

/* logic/boothMultiplier.sv */
// Booth product register and step counter for signed multiplication
// Stepped by the controller with alternating step and shift strobes
`default_nettype none
`timescale 1ns/10ps

module boothMultiplier import calcPkg::*; #(
	parameter int Width = defaultWidth
) (
	input wire Clock,
	input wire reset,
	input wire mulStart,
	input wire mulStep,
	input wire mulShift,
	input wire [Width-1:0] multiplicand,
	input wire [Width-1:0] sum,
	input wire sumOverflow,
	output logic [Width-1:0] productHigh,
	output logic [Width-1:0] productLow,
	output logic boothSubtract,
	output logic mulDone,
	output logic productOverflow
);

	localparam int countWidth = $clog2(Width + 1);

	// Layout is upper half of W+1 bits, low half of W bits, one guard bit
	logic [2*Width+1:0] product;
	logic [countWidth-1:0] stepCount;
	logic [Width+1:0] upperBits;
	logic boothActive;

	// ------------------------------
	// Booth pair decode
	// ------------------------------

	// Pair 10 subtracts and pair 01 adds
	assign boothSubtract = product[1] & ~product[0];
	assign boothActive = product[1] ^ product[0];

	// Adder sees the upper half without its extra sign bit
	assign productHigh = product[2*Width:Width+1];
	assign productLow = product[Width:1];

	// Upper half must be all copies of the low half's sign
	assign upperBits = product[2*Width+1:Width];
	assign productOverflow = !((&upperBits) || !(|upperBits));

	// Product register carries no reset
	always_ff @(posedge Clock) begin
		if (mulStart) begin
			product <= {{(Width + 1){1'b0}}, multiplicand, 1'b0};
		end else if (mulStep && !mulDone && boothActive) begin
			// Sign corrected when the adder overflows
			product[2*Width+1:Width+1] <= {sum[Width-1] ^ sumOverflow, sum};
		end else if (mulShift) begin
			// Arithmetic shift right of the whole register
			product <= {product[2*Width+1], product[2*Width+1:1]};
		end
	end

	// ------------------------------
	// Step counter
	// ------------------------------

	always_ff @(posedge Clock) begin
		if (reset) begin
			stepCount <= '0;
			mulDone <= 1'b0;
		end else if (mulStart) begin
			stepCount <= countWidth'(Width);
			mulDone <= 1'b0;
		end else if (mulShift && !mulDone) begin
			stepCount <= stepCount - 1'b1;
			// Set together with the counter reaching zero
			mulDone <= (stepCount == countWidth'(1));
		end
	end

endmodule

`default_nettype wire

/* logic/calcDatapath.sv */
// Shared datapath with accumulator, operand latch, adder and Booth multiplier
// Driven by the controller command lines
`default_nettype none
`timescale 1ns/10ps

module calcDatapath import calcPkg::*; #(
	parameter int Width = defaultWidth
) (
	input wire Clock,
	input wire reset,
	input wire [Width-1:0] Number,
	input wire [accCmdWidth-1:0] accCmd,
	input wire captureNumber,
	input wire subtract,
	input wire mulStart,
	input wire mulStep,
	input wire mulShift,
	output logic [Width-1:0] Result,
	output logic sumOverflow,
	output logic productOverflow,
	output logic mulDone
);

	logic [Width-1:0] accumulator;
	logic [Width-1:0] operand;
	logic [Width-1:0] addA;
	logic [Width-1:0] sum;
	logic [Width-1:0] productHigh;
	logic [Width-1:0] productLow;
	logic addSubtract;
	logic boothSubtract;

	operandLatch #(.Width(Width)) u_operandLatch (
		.Clock(Clock),
		.reset(reset),
		.captureNumber(captureNumber),
		.Number(Number),
		.operand(operand)
	);

	// ------------------------------
	// Adder operand routing
	// ------------------------------

	// Booth steps work on the upper product half
	assign addA = mulStep ? productHigh : accumulator;
	assign addSubtract = mulStep ? boothSubtract : subtract;

	addSub #(.Width(Width)) u_addSub (
		.a(addA),
		.b(operand),
		.subtract(addSubtract),
		.sum(sum),
		.overflow(sumOverflow)
	);

	// Accumulator is the multiplicand and the latched operand the multiplier
	boothMultiplier #(.Width(Width)) u_boothMultiplier (
		.Clock(Clock),
		.reset(reset),
		.mulStart(mulStart),
		.mulStep(mulStep),
		.mulShift(mulShift),
		.multiplicand(accumulator),
		.sum(sum),
		.sumOverflow(sumOverflow),
		.productHigh(productHigh),
		.productLow(productLow),
		.boothSubtract(boothSubtract),
		.mulDone(mulDone),
		.productOverflow(productOverflow)
	);

	// Accumulator load select
	always_ff @(posedge Clock) begin
		if (reset) begin
			accumulator <= '0;
		end else begin
			case (accCmd)
				accClear: accumulator <= '0;
				accLoadNumber: accumulator <= operand;
				accLoadSum: accumulator <= sum;
				accLoadProduct: accumulator <= productLow;
				default: accumulator <= accumulator;
			endcase
		end
	end

	assign Result = accumulator;

endmodule

`default_nettype wire

/* logic/calcController.sv */
// Button-driven FSM of the calculator
// Decodes datapath commands from the state and holds the sticky overflow flag
`default_nettype none
`timescale 1ns/10ps

module calcController import calcPkg::*; #(
	parameter int Width = defaultWidth
) (
	input wire Clock,
	input wire reset,
	input wire Clear,
	input wire Equals,
	input wire Add,
	input wire Subtract,
	input wire Multiply,
	input wire sumOverflow,
	input wire productOverflow,
	input wire mulDone,
	output logic [accCmdWidth-1:0] accCmd,
	output logic captureNumber,
	output logic subtract,
	output logic mulStart,
	output logic mulStep,
	output logic mulShift,
	output logic Overflow
);

	// ------------------------------
	// States
	// ------------------------------

	localparam logic [3:0] stInit = 4'd0;
	localparam logic [3:0] stIdle = 4'd1;
	// Operand entry per operator
	localparam logic [3:0] stAddEntry = 4'd2;
	localparam logic [3:0] stSubEntry = 4'd3;
	localparam logic [3:0] stMulEntry = 4'd4;
	// Equals without operator
	localparam logic [3:0] stNumCapture = 4'd5;
	localparam logic [3:0] stNumLoad = 4'd6;
	localparam logic [3:0] stAddCompute = 4'd7;
	localparam logic [3:0] stSubCompute = 4'd8;
	localparam logic [3:0] stAddLoad = 4'd9;
	localparam logic [3:0] stSubLoad = 4'd10;
	// Multiply loop
	localparam logic [3:0] stMulBegin = 4'd11;
	localparam logic [3:0] stMulStep = 4'd12;
	localparam logic [3:0] stMulShift = 4'd13;
	localparam logic [3:0] stMulLoad = 4'd14;
	localparam logic [3:0] stOverflow = 4'd15;

	logic [3:0] state;
	logic [3:0] nextState;

	// Sign bit plus a few magnitude bits at least
	if (Width < 4) begin : gWidthCheck
		$error("calcController needs Width of at least 4");
	end

	always_comb begin
		nextState = state;
		case (state)
			stInit, stIdle: begin
				if (Equals) nextState = stNumCapture;
				else if (Add) nextState = stAddEntry;
				else if (Subtract) nextState = stSubEntry;
				else if (Multiply) nextState = stMulEntry;
			end
			stAddEntry: if (Equals) nextState = stAddCompute;
			stSubEntry: if (Equals) nextState = stSubCompute;
			stMulEntry: if (Equals) nextState = stMulBegin;
			stNumCapture: nextState = stNumLoad;
			// Adder result is settled here
			stAddCompute: nextState = sumOverflow ? stOverflow : stAddLoad;
			stSubCompute: nextState = sumOverflow ? stOverflow : stSubLoad;
			stMulBegin: nextState = stMulStep;
			// Step state doubles as completion check
			stMulStep: begin
				if (!mulDone) nextState = stMulShift;
				else if (productOverflow) nextState = stOverflow;
				else nextState = stMulLoad;
			end
			stMulShift: nextState = stMulStep;
			stNumLoad, stAddLoad, stSubLoad, stMulLoad: nextState = stIdle;
			// Left only by Clear or reset
			stOverflow: nextState = stOverflow;
			default: nextState = stInit;
		endcase
	end

	// Clear acts from every state
	always_ff @(posedge Clock) begin
		if (reset || Clear) begin
			state <= stInit;
		end else begin
			state <= nextState;
		end
	end

	// Flag trails the state by one edge to line up with the load edge
	always_ff @(posedge Clock) begin
		if (reset || Clear) begin
			Overflow <= 1'b0;
		end else begin
			Overflow <= (state == stOverflow);
		end
	end

	// ------------------------------
	// Command decode
	// ------------------------------

	always_comb begin
		case (state)
			stInit: accCmd = accClear;
			stNumLoad: accCmd = accLoadNumber;
			stAddLoad, stSubLoad: accCmd = accLoadSum;
			stMulLoad: accCmd = accLoadProduct;
			default: accCmd = accHold;
		endcase
	end

	// Latch stays open for the whole entry
	assign captureNumber = (state == stAddEntry) || (state == stSubEntry)
		|| (state == stMulEntry) || (state == stNumCapture);
	assign subtract = (state == stSubCompute) || (state == stSubLoad);
	assign mulStart = (state == stMulBegin);
	assign mulStep = (state == stMulStep);
	assign mulShift = (state == stMulShift);

endmodule

`default_nettype wire

/* logic/fourFuncCalc.sv */
// Top level of the button calculator core
// Joins the button FSM to the shared datapath
`default_nettype none
`timescale 1ns/10ps

module fourFuncCalc import calcPkg::*; #(
	parameter int Width = defaultWidth
) (
	input wire Clock,
	input wire reset,
	input wire Clear,
	input wire Equals,
	input wire Add,
	input wire Subtract,
	input wire Multiply,
	input wire [Width-1:0] Number,
	output logic [Width-1:0] Result,
	output logic Overflow
);

	// Controller to datapath
	logic [accCmdWidth-1:0] accCmd;
	logic captureNumber;
	logic subtract;
	logic mulStart;
	logic mulStep;
	logic mulShift;

	// Datapath status
	logic sumOverflow;
	logic productOverflow;
	logic mulDone;

	calcController #(.Width(Width)) u_calcController (
		.Clock(Clock),
		.reset(reset),
		.Clear(Clear),
		.Equals(Equals),
		.Add(Add),
		.Subtract(Subtract),
		.Multiply(Multiply),
		.sumOverflow(sumOverflow),
		.productOverflow(productOverflow),
		.mulDone(mulDone),
		.accCmd(accCmd),
		.captureNumber(captureNumber),
		.subtract(subtract),
		.mulStart(mulStart),
		.mulStep(mulStep),
		.mulShift(mulShift),
		.Overflow(Overflow)
	);

	calcDatapath #(.Width(Width)) u_calcDatapath (
		.Clock(Clock),
		.reset(reset),
		.Number(Number),
		.accCmd(accCmd),
		.captureNumber(captureNumber),
		.subtract(subtract),
		.mulStart(mulStart),
		.mulStep(mulStep),
		.mulShift(mulShift),
		.Result(Result),
		.sumOverflow(sumOverflow),
		.productOverflow(productOverflow),
		.mulDone(mulDone)
	);

endmodule

`default_nettype wire

/* verif/fourFuncCalc_assertions.sv */
// Bound checks on the overflow behavior of the calculator FSM
// Attached to calcController from the testbench top
`default_nettype none
`timescale 1ns/10ps

module fourFuncCalc_assertions import calcPkg::*; (
	input wire Clock,
	input wire reset,
	input wire Clear,
	input wire Overflow,
	input wire [accCmdWidth-1:0] accCmd
);

	// Failed assertions, read back by the testbench summary
	int failureCount = 0;

	// Sticky until Clear or reset
	overflowSticky: assert property (@(posedge Clock) disable iff (reset)
		Overflow && !Clear |=> Overflow)
	else begin
		failureCount++;
		$error("Overflow dropped without Clear or reset");
	end

	// Accumulator frozen, so Result cannot move
	resultHeld: assert property (@(posedge Clock) disable iff (reset)
		Overflow |-> accCmd == accHold)
	else begin
		failureCount++;
		$error("Accumulator command not hold while Overflow is high");
	end

	resetClearsOverflow: assert property (@(posedge Clock) reset |=> !Overflow)
	else begin
		failureCount++;
		$error("Overflow high in the cycle after reset");
	end

endmodule

`default_nettype wire

/* verif/fourFuncCalcTb.sv */
// Directed testbench for the calculator core
// Runs load, add/subtract, overflow and multiply tests against a reference model
`default_nettype none
`timescale 1ns/10ps

module fourFuncCalcTb import calcPkg::*; ();

	localparam int Width = defaultWidth;
	localparam int clockPeriod = 20;
	localparam int resetCycles = 8;
	localparam int maxMagnitude = (1 << (Width - 1)) - 1;
	localparam int mulLatency = 2 * Width + 3;
	localparam int numChainOps = 12;
	localparam int numRandomMuls = 10;
	// Longest operation plus the button presses around it
	localparam int opCycles = mulLatency + 6;
	localparam int numOps = 50 + numChainOps + 3 * numRandomMuls;
	localparam int watchdogCycles = 2 * (resetCycles + numOps * opCycles);

	localparam int buttonClear = 0;
	localparam int buttonEquals = 1;
	localparam int buttonAdd = 2;
	localparam int buttonSubtract = 3;
	localparam int buttonMultiply = 4;

	logic Clock;
	logic reset;
	logic Clear;
	logic Equals;
	logic Add;
	logic Subtract;
	logic Multiply;
	logic [Width-1:0] Number;
	logic [Width-1:0] Result;
	logic Overflow;

	int errorCount;
	// Reference model of A and the sticky flag
	int modelAcc;
	bit modelOverflow;

	fourFuncCalc u_dut (
		.Clock(Clock),
		.reset(reset),
		.Clear(Clear),
		.Equals(Equals),
		.Add(Add),
		.Subtract(Subtract),
		.Multiply(Multiply),
		.Number(Number),
		.Result(Result),
		.Overflow(Overflow)
	);

	bind calcController fourFuncCalc_assertions u_assertions (
		.Clock(Clock),
		.reset(reset),
		.Clear(Clear),
		.Overflow(Overflow),
		.accCmd(accCmd)
	);

	initial begin
		Clock = 1'b0;
		forever #(clockPeriod / 2) Clock = ~Clock;
	end

	// Watchdog
	initial begin
		#(watchdogCycles * clockPeriod);
		$display("Timeout after %0d cycles, the test sequence did not finish", watchdogCycles);
		$display("CHECKS FAILED");
		$finish;
	end

	// ------------------------------
	// Model helpers
	// ------------------------------

	function automatic int signMagValue(input logic [Width-1:0] signMag);
		int magnitude;
		magnitude = int'(signMag[Width-2:0]);
		return signMag[Width-1] ? -magnitude : magnitude;
	endfunction

	function automatic logic [Width-1:0] makeSignMag(input bit negative, input int magnitude);
		return {negative, magnitude[Width-2:0]};
	endfunction

	function automatic bit inRange(input int value);
		return (value >= -(maxMagnitude + 1)) && (value <= maxMagnitude);
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			errorCount++;
			$display("[ERROR] %0t ns: %s got %0h, expected %0h", $time, name, actual, expected);
		end
	endtask

	task automatic checkOutputs(input string label, input int expectedAcc,
		input bit expectedOverflow);
		checkValue({label, " Result"}, Result, expectedAcc[Width-1:0]);
		checkValue({label, " Overflow"}, Overflow, expectedOverflow);
	endtask

	// ------------------------------
	// Stimulus
	// ------------------------------

	// One-cycle strobe, returns on the falling edge after the sampling edge
	task automatic pulseButton(input int button);
		@(negedge Clock);
		case (button)
			buttonClear: Clear = 1'b1;
			buttonEquals: Equals = 1'b1;
			buttonAdd: Add = 1'b1;
			buttonSubtract: Subtract = 1'b1;
			default: Multiply = 1'b1;
		endcase
		@(negedge Clock);
		{Clear, Equals, Add, Subtract, Multiply} = '0;
	endtask

	task automatic pressClear(input string label);
		pulseButton(buttonClear);
		// A clears one edge after the FSM reaches init
		@(negedge Clock);
		modelAcc = 0;
		modelOverflow = 1'b0;
		checkOutputs(label, 0, 1'b0);
	endtask

	// Old value one edge early, new value exactly at the latency
	task automatic awaitResult(input string label, input int latency, input int prevAcc,
		input bit prevOverflow);
		repeat (latency - 1) @(negedge Clock);
		checkOutputs({label, " early"}, prevAcc, prevOverflow);
		@(negedge Clock);
		checkOutputs(label, modelAcc, modelOverflow);
	endtask

	task automatic loadNumber(input logic [Width-1:0] signMag);
		int prevAcc;
		bit prevOverflow;
		prevAcc = modelAcc;
		prevOverflow = modelOverflow;
		if (!modelOverflow) begin
			modelAcc = signMagValue(signMag);
		end
		Number = signMag;
		pulseButton(buttonEquals);
		awaitResult("load", 2, prevAcc, prevOverflow);
	endtask

	task automatic runOperation(input int button, input logic [Width-1:0] signMag);
		int prevAcc;
		bit prevOverflow;
		int candidate;
		int latency;
		string label;
		prevAcc = modelAcc;
		prevOverflow = modelOverflow;
		case (button)
			buttonAdd: candidate = modelAcc + signMagValue(signMag);
			buttonSubtract: candidate = modelAcc - signMagValue(signMag);
			default: candidate = modelAcc * signMagValue(signMag);
		endcase
		label = (button == buttonAdd) ? "add" : (button == buttonSubtract) ? "sub" : "mul";
		latency = (button == buttonMultiply) ? mulLatency : 2;
		// Strobes are ignored once overflow is set
		if (!modelOverflow) begin
			if (inRange(candidate)) begin
				modelAcc = candidate;
			end else begin
				modelOverflow = 1'b1;
			end
		end
		pulseButton(button);
		// Entry open, still at the falling edge
		Number = signMag;
		pulseButton(buttonEquals);
		awaitResult(label, latency, prevAcc, prevOverflow);
	endtask

	// ------------------------------
	// Directed tests
	// ------------------------------

	task automatic testResetAndClear();
		checkOutputs("reset", 0, 1'b0);
		loadNumber(makeSignMag(1'b0, 123));
		pressClear("clear");
	endtask

	task automatic testNumberLoad();
		logic [Width-1:0] entries [5];
		// Negative zero must read as plain zero
		entries = '{makeSignMag(1'b0, 300), makeSignMag(1'b1, 5), makeSignMag(1'b1, 0),
			makeSignMag(1'b0, maxMagnitude), makeSignMag(1'b1, maxMagnitude)};
		foreach (entries[i]) begin
			pressClear("load setup");
			loadNumber(entries[i]);
		end
	endtask

	task automatic testAddSubChain();
		logic [Width-1:0] signMag;
		int button;
		pressClear("chain setup");
		loadNumber(makeSignMag($urandom_range(0, 1) == 1, $urandom_range(0, maxMagnitude)));
		for (int i = 0; i < numChainOps; i++) begin
			signMag = makeSignMag($urandom_range(0, 1) == 1, $urandom_range(0, maxMagnitude));
			button = ($urandom_range(0, 1) == 1) ? buttonAdd : buttonSubtract;
			// Flip the operator to stay in range
			if (button == buttonAdd && !inRange(modelAcc + signMagValue(signMag))) begin
				button = buttonSubtract;
			end else if (button == buttonSubtract
				&& !inRange(modelAcc - signMagValue(signMag))) begin
				button = buttonAdd;
			end
			runOperation(button, signMag);
		end
	endtask

	task automatic testAddSubOverflow();
		pressClear("overflow setup");
		loadNumber(makeSignMag(1'b0, 1000));
		runOperation(buttonAdd, makeSignMag(1'b0, 100));
		// FSM parked in overflow, none of these may change anything
		runOperation(buttonMultiply, makeSignMag(1'b0, 2));
		runOperation(buttonSubtract, makeSignMag(1'b0, 1));
		loadNumber(makeSignMag(1'b1, 7));
		pressClear("overflow clear");
		loadNumber(makeSignMag(1'b1, 1000));
		runOperation(buttonSubtract, makeSignMag(1'b0, 200));
		pressClear("overflow clear");
	endtask

	task automatic multiplyCase(input logic [Width-1:0] a, input logic [Width-1:0] b);
		pressClear("multiply setup");
		loadNumber(a);
		runOperation(buttonMultiply, b);
	endtask

	task automatic testMultiply();
		int magLimit;
		multiplyCase(makeSignMag(1'b1, 7), makeSignMag(1'b1, 9));
		multiplyCase(makeSignMag(1'b0, 45), makeSignMag(1'b1, 22));
		multiplyCase(makeSignMag(1'b1, maxMagnitude), makeSignMag(1'b0, 1));
		multiplyCase(makeSignMag(1'b0, 0), makeSignMag(1'b1, 500));
		// Exactly the most negative value
		multiplyCase(makeSignMag(1'b1, 64), makeSignMag(1'b0, 16));
		multiplyCase(makeSignMag(1'b0, 64), makeSignMag(1'b0, 16));
		multiplyCase(makeSignMag(1'b0, 100), makeSignMag(1'b1, 50));
		for (int i = 0; i < numRandomMuls; i++) begin
			// Odd rounds are full range and mostly overflow
			magLimit = (i % 2 == 1) ? maxMagnitude : 31;
			multiplyCase(makeSignMag($urandom_range(0, 1) == 1, $urandom_range(0, magLimit)),
				makeSignMag($urandom_range(0, 1) == 1, $urandom_range(0, magLimit)));
		end
		pressClear("multiply end");
	endtask

	// ------------------------------
	// Sequence
	// ------------------------------

	initial begin
		void'($urandom(40));
		errorCount = 0;
		modelAcc = 0;
		modelOverflow = 1'b0;
		reset = 1'b1;
		{Clear, Equals, Add, Subtract, Multiply} = '0;
		Number = '0;
		repeat (resetCycles) @(posedge Clock);
		@(negedge Clock);
		reset = 1'b0;

		testResetAndClear();
		testNumberLoad();
		testAddSubChain();
		testAddSubOverflow();
		testMultiply();

		$display("Errors: %0d value mismatches, %0d assertion failures", errorCount,
			u_dut.u_calcController.u_assertions.failureCount);
		if (errorCount == 0 && u_dut.u_calcController.u_assertions.failureCount == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* fourFuncCalc.f */
logic/calcPkg.sv
logic/operandLatch.sv
logic/addSub.sv
logic/boothMultiplier.sv
logic/calcDatapath.sv
logic/calcController.sv
logic/fourFuncCalc.sv
verif/fourFuncCalc_assertions.sv
verif/fourFuncCalcTb.sv
